//--- flist.f
verilog/mrx_pkg.sv
verilog/manchester_decoder.sv
verilog/frame_delimiter.sv
verilog/octet_packer.sv
verilog/frame_writer.sv
verilog/manchester_rx.sv
tests/tb_manchester_rx.sv

//--- run.sh
#!/bin/sh
# builds and runs the Manchester receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_manchester_rx -Mdir obj_dir -f flist.f

out=$(./obj_dir/Vtb_manchester_rx)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"

//--- tests/tb_manchester_rx.sv
`timescale 1ns/10ps

module tb_manchester_rx;
  import mrx_pkg::*;

  localparam int HALF_BIT   = 4;
  localparam int MIN_LEN    = 8;
  localparam int WAIT_LIMIT = 400;  // cycles to wait for frame_done

  logic        CLK;
  logic        RST;
  logic        wire_in;
  addr_t       mem_addr;
  word_t       mem_data;
  logic        mem_write;
  len_t        frame_len;
  logic        frame_done;
  logic        frame_ok;

  octet_t      payload [0:63];
  int          pay_len;
  int          exp_words;
  logic        exp_ok;
  string       test_name;
  logic [15:0] lfsr;
  int          wr_seen;      // writes in the current frame
  int          done_seen;
  int          frames_sent;
  int          n_checks;
  int          n_mismatch;
  int          n_other;

  manchester_rx #(.HALF_BIT(HALF_BIT), .MIN_LEN(MIN_LEN)) u_manchester_rx
    (.CLK(CLK), .RST(RST), .wire_in(wire_in), .mem_addr(mem_addr),
     .mem_data(mem_data), .mem_write(mem_write), .frame_len(frame_len),
     .frame_done(frame_done), .frame_ok(frame_ok));

  always #5 CLK = ~CLK;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic random_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  // word k of the frame, earliest octet in the top byte, zero padded
  function automatic word_t ref_word(input int k);
    word_t  w;
    octet_t b;
    int     j;
    w = '0;
    for (j = 0; j < 4; j++)
    begin
      b = (4 * k + j < pay_len) ? payload[4 * k + j] : 8'h00;
      w = {w[23:0], b};
    end
    return w;
  endfunction

  function automatic logic ref_ok(input int len, input int extra);
    return (extra == 0) && (len >= MIN_LEN);  // whole octets and long enough
  endfunction

  task automatic drive_half(input logic level);
    repeat (HALF_BIT)
    begin
      @(posedge CLK);
      wire_in <= level;
    end
  endtask

  task automatic send_bit(input logic b);
    drive_half(!b);  // a 1 is low then high
    drive_half(b);
  endtask

  task automatic send_octet(input octet_t o);
    repeat (8)
    begin
      send_bit(o[0]);  // lsb first
      o = o >> 1;
    end
  endtask

  task automatic run_frame(input string name, input int n_octets, input int extra);
    int     i;
    int     n;
    int     target;
    octet_t b;
    test_name = name;
    pay_len   = n_octets;
    for (i = 0; i < n_octets; i++)
    begin
      repeat (8)
        b = {random_bit(), b[7:1]};
      payload[i] = b;
    end
    exp_words = (n_octets + 3) / 4;
    exp_ok    = ref_ok(n_octets, extra);
    target    = done_seen + 1;
    frames_sent++;

    repeat (7)
      send_octet(8'h55);  // preamble
    send_octet(8'hD5);    // start of frame delimiter
    for (i = 0; i < n_octets; i++)
      send_octet(payload[i]);
    repeat (extra)
      send_bit(random_bit());
    repeat (6 * HALF_BIT)
    begin
      @(posedge CLK);
      wire_in <= 1'b0;  // carrier off
    end

    n = 0;
    while (done_seen < target && n < WAIT_LIMIT)
    begin
      @(posedge CLK);
      n++;
    end
    if (done_seen < target)
    begin
      $display("%s: timeout while waiting for frame_done", name);
      n_other++;
    end
  endtask

  // compares every memory write and every frame result
  always @(posedge CLK)
  begin
    if (mem_write)
    begin
      if (wr_seen >= exp_words)
      begin
        $display("%s: unexpected write to address %0d", test_name, mem_addr);
        n_other++;
      end
      else
      begin
        n_checks += 2;
        if (mem_addr != addr_t'(wr_seen))
        begin
          $display("Mismatch %s mem_addr: expected %0d actual %0d",
                   test_name, wr_seen, mem_addr);
          n_mismatch++;
        end
        if (mem_data != ref_word(wr_seen))
        begin
          $display("Mismatch %s mem_data: expected %h actual %h",
                   test_name, ref_word(wr_seen), mem_data);
          n_mismatch++;
        end
      end
      wr_seen++;
    end
    if (frame_done)
    begin
      if (done_seen >= frames_sent)
      begin
        $display("%s: frame_done without a frame on the wire", test_name);
        n_other++;
      end
      else
      begin
        n_checks += 2;
        if (frame_len != len_t'(pay_len))
        begin
          $display("Mismatch %s frame_len: expected %0d actual %0d",
                   test_name, pay_len, frame_len);
          n_mismatch++;
        end
        if (frame_ok != exp_ok)
        begin
          $display("Mismatch %s frame_ok: expected %b actual %b",
                   test_name, exp_ok, frame_ok);
          n_mismatch++;
        end
        if (wr_seen != exp_words)
        begin
          $display("%s: %0d words written where %0d were due",
                   test_name, wr_seen, exp_words);
          n_other++;
        end
      end
      wr_seen = 0;  // next frame starts at address 0
      done_seen++;
    end
  end

  initial
  begin
    CLK         = 1'b0;
    RST         = 1'b0;
    wire_in     = 1'b0;
    lfsr        = 16'd96;
    pay_len     = 0;
    exp_words   = 0;
    exp_ok      = 1'b0;
    test_name   = "reset";
    wr_seen     = 0;
    done_seen   = 0;
    frames_sent = 0;
    n_checks    = 0;
    n_mismatch  = 0;
    n_other     = 0;

    repeat (10)
      @(posedge CLK);
    RST <= 1'b1;
    test_name = "idle_wire";
    repeat (50)
      @(posedge CLK);  // any write or done here is flagged

    run_frame("full_words", 20, 0);
    run_frame("partial_word", 22, 0);
    run_frame("short_frame", 5, 0);
    run_frame("unaligned", 12, 3);
    run_frame("back_to_back_a", 16, 0);
    run_frame("back_to_back_b", 9, 0);

    $display("checks %0d, mismatches %0d, other errors %0d",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- verilog/manchester_rx.sv
`timescale 1ns/10ps

module manchester_rx
  #(
    parameter int HALF_BIT = 4,
    parameter int MIN_LEN  = 8
  )
  (
    input  logic           CLK,
    input  logic           RST,
    input  logic           wire_in,
    output mrx_pkg::addr_t mem_addr,
    output mrx_pkg::word_t mem_data,
    output logic           mem_write,
    output mrx_pkg::len_t  frame_len,
    output logic           frame_done,
    output logic           frame_ok
  );
  import mrx_pkg::*;

  rx_bit_t    rx_bit;
  frame_ctl_t frame_ctl;
  rx_octet_t  rx_octet;

  manchester_decoder #(.HALF_BIT(HALF_BIT)) u_decoder
    (.CLK(CLK), .RST(RST), .wire_in(wire_in), .rx_bit(rx_bit));

  frame_delimiter u_delimiter
    (.CLK(CLK), .RST(RST), .rx_bit(rx_bit), .frame_ctl(frame_ctl));

  // packer and delimiter both follow the raw bit stream
  octet_packer u_packer
    (.CLK(CLK), .RST(RST), .rx_bit(rx_bit), .frame_ctl(frame_ctl),
     .rx_octet(rx_octet));

  frame_writer #(.MIN_LEN(MIN_LEN)) u_writer
    (.CLK(CLK), .RST(RST), .frame_ctl(frame_ctl), .rx_octet(rx_octet),
     .mem_addr(mem_addr), .mem_data(mem_data), .mem_write(mem_write),
     .frame_len(frame_len), .frame_done(frame_done), .frame_ok(frame_ok));

endmodule

//--- verilog/frame_writer.sv
`timescale 1ns/10ps

module frame_writer
  #(
    parameter int MIN_LEN = 8
  )
  (
    input  logic                CLK,
    input  logic                RST,
    input  mrx_pkg::frame_ctl_t frame_ctl,
    input  mrx_pkg::rx_octet_t  rx_octet,
    output mrx_pkg::addr_t      mem_addr,
    output mrx_pkg::word_t      mem_data,
    output logic                mem_write,
    output mrx_pkg::len_t       frame_len,
    output logic                frame_done,
    output logic                frame_ok
  );
  import mrx_pkg::*;

  logic [1:0] byte_idx;  // next byte lane, top lane first
  addr_t      wr_addr;
  len_t       len_q;
  word_t      word_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      byte_idx   <= '0;
      wr_addr    <= '0;
      len_q      <= '0;
      mem_write  <= 1'b0;
      frame_done <= 1'b0;
      frame_ok   <= 1'b0;
    end
    else
    begin
      mem_write  <= 1'b0;
      frame_done <= 1'b0;
      frame_ok   <= 1'b0;
      if (frame_ctl.start)
      begin
        byte_idx <= '0;
        wr_addr  <= '0;
        len_q    <= '0;
      end
      else if (rx_octet.valid)
      begin
        byte_idx <= byte_idx + 2'd1;
        len_q    <= len_q + len_t'(1);
        if (byte_idx == 2'd3)
        begin
          mem_write <= 1'b1;  // word complete
          wr_addr   <= wr_addr + addr_t'(1);
        end
      end
      else if (frame_ctl.stop)
      begin
        mem_write  <= (byte_idx != 2'd0);  // flush partial word
        frame_done <= 1'b1;
        frame_ok   <= rx_octet.aligned && (len_q >= len_t'(MIN_LEN));
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (rx_octet.valid)
    begin
      if (byte_idx == 2'd0)
        word_q <= {rx_octet.data, 24'h0};  // low lanes start out zero
      else
        word_q[8 * (3 - byte_idx) +: 8] <= rx_octet.data;

      if (byte_idx == 2'd3)
      begin
        mem_data <= {word_q[31:8], rx_octet.data};
        mem_addr <= wr_addr;
      end
    end
    else if (frame_ctl.stop)
    begin
      mem_data  <= word_q;
      mem_addr  <= wr_addr;
      frame_len <= len_q;
    end
  end

  // writes only from a live frame or the flush right after it
  assert property (@(posedge CLK) disable iff (!RST)
    mem_write |-> $past(frame_ctl.active || frame_ctl.stop));

endmodule

//--- verilog/octet_packer.sv
`timescale 1ns/10ps

module octet_packer
  (
    input  logic                CLK,
    input  logic                RST,
    input  mrx_pkg::rx_bit_t    rx_bit,
    input  mrx_pkg::frame_ctl_t frame_ctl,
    output mrx_pkg::rx_octet_t  rx_octet
  );
  import mrx_pkg::*;

  logic [2:0] bit_cnt;
  logic       shift_en;
  logic       oct_valid;
  octet_t     shreg;
  octet_t     shreg_next;
  octet_t     oct_data;

  // the delimiter bit itself is not frame data
  assign shift_en   = rx_bit.valid && frame_ctl.active && !frame_ctl.start;
  assign shreg_next = {rx_bit.value, shreg[7:1]};  // lsb arrives first

  assign rx_octet.data    = oct_data;
  assign rx_octet.valid   = oct_valid;
  assign rx_octet.aligned = (bit_cnt == 3'd0);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      bit_cnt   <= '0;
      oct_valid <= 1'b0;
    end
    else
    begin
      oct_valid <= shift_en && (bit_cnt == 3'd7);  // count wraps
      if (frame_ctl.start)
        bit_cnt <= '0;
      else if (shift_en)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (shift_en)
      shreg <= shreg_next;
    if (shift_en && (bit_cnt == 3'd7))
      oct_data <= shreg_next;
  end

endmodule

//--- verilog/frame_delimiter.sv
`timescale 1ns/10ps

module frame_delimiter
  (
    input  logic                CLK,
    input  logic                RST,
    input  mrx_pkg::rx_bit_t    rx_bit,
    output mrx_pkg::frame_ctl_t frame_ctl
  );
  import mrx_pkg::*;

  localparam logic [2:0] PRE_MIN = 3'd4;  // alternating bits before 1-1

  logic       prev_bit;
  logic [2:0] alt_cnt;
  logic       active_q;  // also marks the delimiter as taken
  logic       sfd_hit;

  assign sfd_hit = rx_bit.valid && rx_bit.value && prev_bit
                   && (alt_cnt >= PRE_MIN) && !active_q;  // once per carrier

  assign frame_ctl.start  = sfd_hit;
  assign frame_ctl.active = (active_q || sfd_hit) && !rx_bit.idle;
  assign frame_ctl.stop   = active_q && rx_bit.idle;

  always_ff @(posedge CLK)
  begin
    if (!RST || rx_bit.idle)
    begin
      prev_bit <= 1'b0;
      alt_cnt  <= '0;
      active_q <= 1'b0;
    end
    else if (rx_bit.valid)
    begin
      prev_bit <= rx_bit.value;
      if (rx_bit.value != prev_bit)
      begin
        if (alt_cnt != PRE_MIN)
          alt_cnt <= alt_cnt + 3'd1;
      end
      else
        alt_cnt <= '0;  // preamble broken

      if (sfd_hit)
        active_q <= 1'b1;
    end
  end

  // a frame never restarts while one is open
  assert property (@(posedge CLK) disable iff (!RST)
    frame_ctl.start |-> !$past(frame_ctl.active));

endmodule

//--- verilog/manchester_decoder.sv
`timescale 1ns/10ps

module manchester_decoder
  #(
    parameter int HALF_BIT = 4
  )
  (
    input  logic             CLK,
    input  logic             RST,
    input  logic             wire_in,
    output mrx_pkg::rx_bit_t rx_bit
  );
  import mrx_pkg::*;

  localparam int TIMEOUT = 4 * HALF_BIT;        // carrier loss
  localparam int MIN_GAP = (3 * HALF_BIT) / 2;  // three quarters of a bit
  localparam int TW = $clog2(TIMEOUT + 1);

  logic          sync_1;
  logic          sync_2;
  logic          wire_prev;
  logic          edge_seen;
  logic          centre;
  logic [TW-1:0] timer;
  dec_state_e    state;

  assign edge_seen = sync_2 ^ wire_prev;
  // boundary transitions come too early and are skipped
  // timer reads one less than the clocks since the last centre
  assign centre = edge_seen && (timer >= TW'(MIN_GAP - 1));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      sync_1    <= 1'b0;
      sync_2    <= 1'b0;
      wire_prev <= 1'b0;
      timer     <= '0;
      state     <= IDLE;
      rx_bit    <= '0;
    end
    else
    begin
      sync_1       <= wire_in;
      sync_2       <= sync_1;
      wire_prev    <= sync_2;
      rx_bit.valid <= 1'b0;
      rx_bit.idle  <= 1'b0;

      if (timer != TW'(TIMEOUT))
        timer <= timer + TW'(1);  // saturates

      case (state)
        IDLE:
        begin
          timer <= '0;
          if (edge_seen)
            state <= SYNC;  // first edge of a carrier
        end
        SYNC, TRACK:
        begin
          if (centre)
          begin
            timer        <= '0;
            state        <= TRACK;
            rx_bit.value <= sync_2;  // level after the centre edge
            rx_bit.valid <= 1'b1;
          end
          else if (timer == TW'(TIMEOUT - 1))
          begin
            state       <= IDLE;
            rx_bit.idle <= (state == TRACK);  // no strobe for a lone glitch
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // a bit and end of carrier never share a cycle
  assert property (@(posedge CLK) disable iff (!RST)
    !(rx_bit.valid && rx_bit.idle));

endmodule

//--- verilog/mrx_pkg.sv
package mrx_pkg;

  typedef logic [7:0]  octet_t;  // one received byte
  typedef logic [31:0] word_t;   // one memory word
  typedef logic [8:0]  addr_t;   // word address, 512 words
  typedef logic [10:0] len_t;    // frame length in octets

  // decoder output, value qualified by valid
  typedef struct packed {
    logic value;
    logic valid;  // new bit strobe
    logic idle;   // end of carrier strobe
  } rx_bit_t;

  typedef struct packed {
    logic start;   // last bit of the delimiter
    logic active;  // frame body level
    logic stop;    // active falling
  } frame_ctl_t;

  typedef struct packed {
    octet_t data;
    logic   valid;
    logic   aligned;  // whole octets so far
  } rx_octet_t;

  typedef enum logic [1:0] {
    IDLE,
    SYNC,
    TRACK
  } dec_state_e;

endpackage
